//--- snes_host_pkg.sv
/*
  Shared definitions for the SNES host glue.
  Bridge addresses are exact word addresses. The region codes compare
  only the top bits of the address. Data-table words follow the host
  slot layout, with slot index 1 as the save slot.
*/

package snes_host_pkg;

  //////////////////////////////////////////////////////////////
  // bus and payload types

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [15:0] key_t;
  typedef logic [31:0] joy_t;
  typedef logic [23:0] rgb_t;
  typedef logic [9:0]  dt_addr_t;

  // controller resync depth
  localparam int SYNC_STAGES = 3;

  //////////////////////////////////////////////////////////////
  // bridge address map

  localparam bridge_addr_t ADDR_MULTITAP   = 32'h0000_0100;
  localparam bridge_addr_t ADDR_LIGHTGUN   = 32'h0000_0104;
  localparam bridge_addr_t ADDR_AIM_SPEED  = 32'h0000_0108;
  localparam bridge_addr_t ADDR_VIDEO_MODE = 32'h0000_0200;

  // read regions, save wins over command
  localparam logic [7:0] CMD_REGION  = 8'hF8;
  localparam logic [3:0] SAVE_REGION = 4'h2;

  //////////////////////////////////////////////////////////////
  // data table

  localparam dt_addr_t DT_ROM_SIZE_ADDR  = 10'd1;
  // slot index 1, word 2*1+1
  localparam dt_addr_t DT_SAVE_SIZE_ADDR = 10'd3;

  localparam int DT_PHASE_BITS = 3;
  localparam logic [DT_PHASE_BITS-1:0] DT_CAPTURE_PHASE = 3'd4;

  localparam bridge_data_t SAVE_SIZE_UNIT = 32'd1024;

  // end-of-line status word bits
  localparam int SLOT_PAL_BIT    = 14;
  localparam int SLOT_ASPECT_BIT = 13;

endpackage

//--- cdc_sync.sv
/*
  Plain flop chain, no gray coding. Multi-bit payloads are only safe
  when they change slowly compared to the clock, as button state does.
*/

`timescale 1ns/1ns

module cdc_sync import snes_host_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_74a,
  input  logic     pll_core_locked,
  input  payload_t din,
  output payload_t dout
);

  payload_t sync_q [SYNC_STAGES];

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= din;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign dout = sync_q[SYNC_STAGES-1];

endmodule

//--- bridge_settings.sv
/*
  Write decode needs the full 32-bit address to match.
  Read data is purely combinational from the address, so the bridge
  must hold the address stable for the read to settle.
*/

`timescale 1ns/1ns

module bridge_settings import snes_host_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,

  input  bridge_data_t cmd_rd_data,
  input  bridge_data_t save_rd_data,

  output logic         multitap_enabled,
  output logic         lightgun_enabled,
  output logic         lightgun_type,
  output logic [7:0]   lightgun_aim_speed,
  output logic         use_4_3_video
);

  ////////////////////////////////////////////////////////////
  // option registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      multitap_enabled   <= 1'b0;
      lightgun_enabled   <= 1'b0;
      lightgun_type      <= 1'b0;
      lightgun_aim_speed <= 8'd0;
      use_4_3_video      <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        ADDR_MULTITAP: begin
          multitap_enabled <= bridge_wr_data[0];
        end
        ADDR_LIGHTGUN: begin
          lightgun_enabled <= bridge_wr_data[0];
          lightgun_type    <= bridge_wr_data[1];
        end
        ADDR_AIM_SPEED: begin
          lightgun_aim_speed <= bridge_wr_data[7:0];
        end
        ADDR_VIDEO_MODE: begin
          use_4_3_video <= bridge_wr_data[0];
        end
        default: begin
          // unmapped, ignore
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    if (bridge_addr[31:28] == SAVE_REGION) begin
      bridge_rd_data = save_rd_data;
    end else if (bridge_addr[31:24] == CMD_REGION) begin
      bridge_rd_data = cmd_rd_data;
    end else begin
      bridge_rd_data = '0;
    end
  end

endmodule

//--- slot_tracker.sv
/*
  Data-slot strobes are single cycle pulses from the command handler.
  The ROM window closes on allcomplete as a level; the save window
  closes only on its rising edge.
*/

`timescale 1ns/1ns

module slot_tracker import snes_host_pkg::*; (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic dataslot_requestread,
  input  logic dataslot_requestwrite,
  input  logic dataslot_allcomplete,
  output logic rom_download,
  output logic save_download
);

  logic allcomplete_prev;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete && !allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      rom_download     <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;

      // set has priority over clear
      if (dataslot_requestwrite) begin
        rom_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        rom_download <= 1'b0;
      end

      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
    end
  end

endmodule

//--- datatable_sequencer.sv
/*
  The data-table port is shared in an 8-cycle round.
  Read data is assumed valid a few cycles after the address settles,
  so the ROM size is sampled late in the read half of the round.
*/

`timescale 1ns/1ns

module datatable_sequencer import snes_host_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  logic [3:0]   sram_size,
  input  bridge_data_t datatable_q,
  output dt_addr_t     datatable_addr,
  output logic         datatable_wren,
  output bridge_data_t datatable_data,
  output bridge_data_t rom_file_size
);

  logic [DT_PHASE_BITS-1:0] phase_q;
  bridge_data_t             save_bytes;

  // size code from the cart header, zero means no save RAM
  assign save_bytes = (sram_size != 4'd0) ? (SAVE_SIZE_UNIT << sram_size) : '0;

  ////////////////////////////////////////////////////////////
  // phase counter and port drive

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase_q        <= '0;
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
      rom_file_size  <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;

      if (phase_q > DT_CAPTURE_PHASE) begin
        // write half, publish save size
        datatable_wren <= 1'b1;
        datatable_addr <= DT_SAVE_SIZE_ADDR;
        datatable_data <= save_bytes;
      end else begin
        // read half, point at ROM size word
        datatable_wren <= 1'b0;
        datatable_addr <= DT_ROM_SIZE_ADDR;

        if (phase_q == DT_CAPTURE_PHASE) begin
          rom_file_size <= datatable_q;
        end
      end
    end
  end

endmodule

//--- video_out_formatter.sv
/*
  Every clock is one pixel; no pixel enable is used.
  The scaler reads the word placed right after the last active pixel
  of a line as its status word, so that cycle must not carry pixel data.
*/

`timescale 1ns/1ns

module video_out_formatter import snes_host_pkg::*; (
  input  logic clk_74a,
  input  logic pll_core_locked,

  input  logic h_blank,
  input  logic v_blank,
  input  logic core_hs,
  input  logic core_vs,
  input  rgb_t core_rgb,
  input  logic pal,
  input  logic use_4_3_video,

  output logic video_de,
  output logic video_hs,
  output logic video_vs,
  output rgb_t video_rgb
);

  logic de;
  logic de_prev;
  logic hs_prev;
  logic vs_prev;
  rgb_t slot_word;

  assign de = !(h_blank || v_blank);

  // end-of-line flags for the scaler
  always_comb begin
    slot_word                  = '0;
    slot_word[SLOT_PAL_BIT]    = pal;
    slot_word[SLOT_ASPECT_BIT] = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev <= de;
      hs_prev <= core_hs;
      vs_prev <= core_vs;

      video_de <= de;
      // single cycle pulse on sync rising edge
      video_hs <= core_hs && !hs_prev;
      video_vs <= core_vs && !vs_prev;

      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

endmodule

//--- snes_host_top.sv
/*
  Host-side glue around the SNES core, all on clk_74a.
  pll_core_locked acts as the asynchronous reset for every block.
  Controller inputs come from another domain and are resynchronized.
*/

`timescale 1ns/1ns

module snes_host_top import snes_host_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  // bridge bus
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,
  input  bridge_data_t cmd_rd_data,
  input  bridge_data_t save_rd_data,

  // settings to core
  output logic         multitap_enabled,
  output logic         lightgun_enabled,
  output logic         lightgun_type,
  output logic [7:0]   lightgun_aim_speed,
  output logic         use_4_3_video,

  // data slots
  input  logic         dataslot_requestread,
  input  logic         dataslot_requestwrite,
  input  logic         dataslot_allcomplete,
  output logic         rom_download,
  output logic         save_download,

  // data table
  input  logic [3:0]   sram_size,
  input  bridge_data_t datatable_q,
  output dt_addr_t     datatable_addr,
  output logic         datatable_wren,
  output bridge_data_t datatable_data,
  output bridge_data_t rom_file_size,

  // video
  input  logic         h_blank,
  input  logic         v_blank,
  input  logic         core_hs,
  input  logic         core_vs,
  input  rgb_t         core_rgb,
  input  logic         pal,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output rgb_t         video_rgb,

  // controllers
  input  key_t         cont1_key,
  input  key_t         cont2_key,
  input  key_t         cont3_key,
  input  key_t         cont4_key,
  input  joy_t         cont1_joy,
  output key_t         pad1_key,
  output key_t         pad2_key,
  output key_t         pad3_key,
  output key_t         pad4_key,
  output joy_t         pad1_joy
);

  //////////////////////////////////////////////////////////////
  // bridge side

  bridge_settings u_settings (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .bridge_rd_data     (bridge_rd_data),
    .cmd_rd_data        (cmd_rd_data),
    .save_rd_data       (save_rd_data),
    .multitap_enabled   (multitap_enabled),
    .lightgun_enabled   (lightgun_enabled),
    .lightgun_type      (lightgun_type),
    .lightgun_aim_speed (lightgun_aim_speed),
    .use_4_3_video      (use_4_3_video)
  );

  slot_tracker u_slots (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .rom_download          (rom_download),
    .save_download         (save_download)
  );

  datatable_sequencer u_datatable (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .sram_size       (sram_size),
    .datatable_q     (datatable_q),
    .datatable_addr  (datatable_addr),
    .datatable_wren  (datatable_wren),
    .datatable_data  (datatable_data),
    .rom_file_size   (rom_file_size)
  );

  //////////////////////////////////////////////////////////////
  // video to scaler

  video_out_formatter u_video (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .core_hs         (core_hs),
    .core_vs         (core_vs),
    .core_rgb        (core_rgb),
    .pal             (pal),
    .use_4_3_video   (use_4_3_video),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

  // controller resync
  cdc_sync #(.payload_t(key_t)) u_sync_key1 (
    .clk_74a (clk_74a), .pll_core_locked (pll_core_locked),
    .din     (cont1_key), .dout (pad1_key)
  );
  cdc_sync #(.payload_t(key_t)) u_sync_key2 (
    .clk_74a (clk_74a), .pll_core_locked (pll_core_locked),
    .din     (cont2_key), .dout (pad2_key)
  );
  cdc_sync #(.payload_t(key_t)) u_sync_key3 (
    .clk_74a (clk_74a), .pll_core_locked (pll_core_locked),
    .din     (cont3_key), .dout (pad3_key)
  );
  cdc_sync #(.payload_t(key_t)) u_sync_key4 (
    .clk_74a (clk_74a), .pll_core_locked (pll_core_locked),
    .din     (cont4_key), .dout (pad4_key)
  );
  cdc_sync #(.payload_t(joy_t)) u_sync_joy1 (
    .clk_74a (clk_74a), .pll_core_locked (pll_core_locked),
    .din     (cont1_joy), .dout (pad1_joy)
  );

endmodule

//--- tb_clock.sv
/*
  Clock and reset source for the testbench.
  pll_core_locked is released on a falling edge, away from the
  rising edge where the DUT samples.
*/

`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_74a,
  output logic pll_core_locked
);

  initial begin
    clk_74a = 1'b0;
    forever #(PERIOD_NS / 2) clk_74a = ~clk_74a;
  end

  initial begin
    pll_core_locked = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
  end

endmodule

//--- tb_snes_host.sv
/*
  Directed tests for the SNES host glue.
  Inputs change on the falling edge and registered outputs are read on
  the next falling edge. The combinational read mux is read on the
  rising edge after its inputs change.
*/

`timescale 1ns/1ns

module tb_snes_host;

  // ten times the roughly 200 cycles the tests take
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  logic [31:0] cmd_rd_data;
  logic [31:0] save_rd_data;
  logic        multitap_enabled;
  logic        lightgun_enabled;
  logic        lightgun_type;
  logic [7:0]  lightgun_aim_speed;
  logic        use_4_3_video;
  logic        dataslot_requestread;
  logic        dataslot_requestwrite;
  logic        dataslot_allcomplete;
  logic        rom_download;
  logic        save_download;
  logic [3:0]  sram_size;
  logic [31:0] datatable_q;
  logic [9:0]  datatable_addr;
  logic        datatable_wren;
  logic [31:0] datatable_data;
  logic [31:0] rom_file_size;
  logic        h_blank;
  logic        v_blank;
  logic        core_hs;
  logic        core_vs;
  logic [23:0] core_rgb;
  logic        pal;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic [23:0] video_rgb;
  logic [15:0] cont1_key;
  logic [15:0] cont2_key;
  logic [15:0] cont3_key;
  logic [15:0] cont4_key;
  logic [31:0] cont1_joy;
  logic [15:0] pad1_key;
  logic [15:0] pad2_key;
  logic [15:0] pad3_key;
  logic [15:0] pad4_key;
  logic [31:0] pad1_joy;

  integer seed = 32'h8798;
  int     errors = 0;
  int     checks = 0;
  int     cycle_count = 0;

  // settings the DUT should hold
  logic       exp_multitap;
  logic       exp_gun_en;
  logic       exp_gun_type;
  logic [7:0] exp_aim;
  logic       exp_43;

  tb_clock u_clock (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked)
  );

  snes_host_top u_dut (.*);

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic check_settings(input string name);
    check({name, " multitap"}, 32'(exp_multitap), 32'(multitap_enabled));
    check({name, " gun enable"}, 32'(exp_gun_en), 32'(lightgun_enabled));
    check({name, " gun type"}, 32'(exp_gun_type), 32'(lightgun_type));
    check({name, " aim speed"}, 32'(exp_aim), 32'(lightgun_aim_speed));
    check({name, " 4:3 video"}, 32'(exp_43), 32'(use_4_3_video));
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_settings();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] first [4];
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 4; i++) begin
        // second pass flips every bit of the first
        data = (pass == 0) ? $random(seed) : ~first[i];
        first[i] = data;
        case (i)
          0: addr = 32'h0000_0100;
          1: addr = 32'h0000_0104;
          2: addr = 32'h0000_0108;
          default: addr = 32'h0000_0200;
        endcase
        bridge_write(addr, data);
        case (i)
          0: exp_multitap = data[0];
          1: begin
            exp_gun_en   = data[0];
            exp_gun_type = data[1];
          end
          2: exp_aim = data[7:0];
          default: exp_43 = data[0];
        endcase
        check_settings("settings write");
      end
    end
    // near misses of the map
    bridge_write(32'h0000_010C, 32'hFFFF_FFFF);
    bridge_write(32'h1000_0100, ~{31'd0, exp_multitap});
    check_settings("settings unmapped");
  endtask

  task automatic test_read_mux();
    logic [31:0] addr;
    logic [31:0] expected;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk_74a);
      cmd_rd_data  = $random(seed);
      save_rd_data = $random(seed);
      addr         = $random(seed);
      case (i % 3)
        0: begin
          addr[31:28] = 4'h2;
          expected    = save_rd_data;
        end
        1: begin
          addr[31:24] = 8'hF8;
          expected    = cmd_rd_data;
        end
        default: begin
          if (addr[31:28] == 4'h2 || addr[31:24] == 8'hF8) begin
            addr[31] = ~addr[31];
          end
          expected = 32'd0;
        end
      endcase
      bridge_addr = addr;
      @(posedge clk_74a);
      check("read mux", expected, bridge_rd_data);
    end
  endtask

  // drives on a falling edge and checks on the next one
  task automatic slot_cycle(input logic rr, input logic rw, input logic ac,
                            input logic exp_rom, input logic exp_save,
                            input string name);
    dataslot_requestread  = rr;
    dataslot_requestwrite = rw;
    dataslot_allcomplete  = ac;
    @(negedge clk_74a);
    check({name, " rom"}, 32'(exp_rom), 32'(rom_download));
    check({name, " save"}, 32'(exp_save), 32'(save_download));
  endtask

  task automatic test_slots();
    @(negedge clk_74a);
    slot_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, "slot requestwrite");
    slot_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, "slot hold");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "slot allcomplete");
    slot_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "slot idle");
    slot_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, "slot requestread");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "slot save edge");
    slot_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, "slot read while held");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "slot held level");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "slot held level");
    slot_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b1, "slot rom set wins");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "slot rom level clear");
    slot_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, "slot release");
    slot_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, "slot save set wins");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "slot edge passed");
    slot_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, "slot release");
    slot_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "slot final edge");
    slot_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "slot idle");
  endtask

  task automatic test_datatable();
    logic [3:0]  size;
    logic [31:0] q;
    logic [31:0] exp_data;
    int          rnd;
    int          wren_count;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk_74a);
      rnd  = $random(seed);
      size = (n == 3) ? 4'd0 : (rnd[3:0] % 4'd15) + 4'd1;
      q    = $random(seed);
      sram_size   = size;
      datatable_q = q;
      exp_data    = (size == 4'd0) ? 32'd0 : (32'd1024 << size);
      wren_count  = 0;
      for (int c = 0; c < 16; c++) begin
        @(negedge clk_74a);
        if (datatable_wren) begin
          wren_count++;
          check("datatable write addr", 32'd3, 32'(datatable_addr));
          check("datatable save size", exp_data, datatable_data);
        end else begin
          check("datatable read addr", 32'd1, 32'(datatable_addr));
        end
      end
      // three write phases in each of two rounds
      check("datatable write phases", 32'd6, 32'(wren_count));
      check("datatable rom size", q, rom_file_size);
    end
  endtask

  task automatic check_video(input logic de, input logic hs, input logic vs,
                             input logic [23:0] rgb);
    check("video de", 32'(de), 32'(video_de));
    check("video hs", 32'(hs), 32'(video_hs));
    check("video vs", 32'(vs), 32'(video_vs));
    check("video rgb", 32'(rgb), 32'(video_rgb));
  endtask

  // blank then 6 active pixels then blank with hs and vs rising
  task automatic video_line(input logic pal_val);
    logic [23:0] status;
    logic [23:0] exp_rgb;
    logic        exp_de;
    logic        exp_hs;
    logic        exp_vs;
    int          rnd;
    status      = 24'd0;
    status[14]  = pal_val;
    status[13]  = exp_43;
    for (int i = 0; i < 15; i++) begin
      @(negedge clk_74a);
      if (i > 0) begin
        check_video(exp_de, exp_hs, exp_vs, exp_rgb);
      end
      rnd      = $random(seed);
      h_blank  = (i < 2) || (i >= 8);
      v_blank  = (i == 0);
      core_hs  = (i >= 9) && (i <= 11);
      core_vs  = (i >= 10);
      core_rgb = rnd[23:0];
      pal      = pal_val;
      // active on 2 to 7, status word on 8, hs rises on 9 and vs on 10
      exp_de = (i >= 2) && (i <= 7);
      exp_hs = (i == 9);
      exp_vs = (i == 10);
      if (exp_de) begin
        exp_rgb = core_rgb;
      end else if (i == 8) begin
        exp_rgb = status;
      end else begin
        exp_rgb = 24'd0;
      end
    end
    @(negedge clk_74a);
    check_video(exp_de, exp_hs, exp_vs, exp_rgb);
    h_blank = 1'b1;
    v_blank = 1'b1;
    core_hs = 1'b0;
    core_vs = 1'b0;
  endtask

  task automatic test_video();
    bridge_write(32'h0000_0200, 32'h1);
    exp_43 = 1'b1;
    video_line(1'b0);
    bridge_write(32'h0000_0200, 32'h0);
    exp_43 = 1'b0;
    video_line(1'b1);
  endtask

  task automatic test_controllers();
    logic [15:0] key_hist [16][4];
    logic [31:0] joy_hist [16];
    int          rnd;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_74a);
      if (i >= 3) begin
        check("pad1 key", 32'(key_hist[i-3][0]), 32'(pad1_key));
        check("pad2 key", 32'(key_hist[i-3][1]), 32'(pad2_key));
        check("pad3 key", 32'(key_hist[i-3][2]), 32'(pad3_key));
        check("pad4 key", 32'(key_hist[i-3][3]), 32'(pad4_key));
        check("pad1 joy", joy_hist[i-3], pad1_joy);
      end
      rnd = $random(seed);
      key_hist[i][0] = rnd[15:0];
      key_hist[i][1] = rnd[31:16];
      rnd = $random(seed);
      key_hist[i][2] = rnd[15:0];
      key_hist[i][3] = rnd[31:16];
      joy_hist[i]    = $random(seed);
      cont1_key = key_hist[i][0];
      cont2_key = key_hist[i][1];
      cont3_key = key_hist[i][2];
      cont4_key = key_hist[i][3];
      cont1_joy = joy_hist[i];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // run control

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    bridge_addr           = 32'd0;
    bridge_wr             = 1'b0;
    bridge_wr_data        = 32'd0;
    cmd_rd_data           = 32'd0;
    save_rd_data          = 32'd0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    sram_size             = 4'd0;
    datatable_q           = 32'd0;
    // idle video is blanked with sync low
    h_blank   = 1'b1;
    v_blank   = 1'b1;
    core_hs   = 1'b0;
    core_vs   = 1'b0;
    core_rgb  = 24'd0;
    pal       = 1'b0;
    cont1_key = 16'd0;
    cont2_key = 16'd0;
    cont3_key = 16'd0;
    cont4_key = 16'd0;
    cont1_joy = 32'd0;
    exp_multitap = 1'b0;
    exp_gun_en   = 1'b0;
    exp_gun_type = 1'b0;
    exp_aim      = 8'd0;
    exp_43       = 1'b0;

    @(posedge pll_core_locked);
    @(negedge clk_74a);
    check_settings("reset");
    check("reset rom download", 32'd0, 32'(rom_download));
    check("reset save download", 32'd0, 32'(save_download));

    test_settings();
    test_read_mux();
    test_slots();
    test_datatable();
    test_video();
    test_controllers();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
snes_host_pkg.sv
cdc_sync.sv
bridge_settings.sv
slot_tracker.sv
datatable_sequencer.sv
video_out_formatter.sv
snes_host_top.sv
tb_clock.sv
tb_snes_host.sv

//--- Makefile
# Verilator build and run for the SNES host glue testbench.
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_snes_host
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
